/* source/beam_pkg.sv */
package beam_pkg;

    // Microphone array and sample format
    localparam int N_MIC    = 4;
    localparam int SAMPLE_W = 12;
    localparam int SUM_W    = 14;             // Four samples summed
    localparam int ACC_W    = 32;             // Map word, holds four frames of squares

    // Ring buffer
    localparam int BUF_DEPTH = 16;
    localparam int PTR_W     = 4;

    // Map geometry, row-major pixel order
    localparam int MAP_COLS = 8;
    localparam int MAP_ROWS = 6;
    localparam int COL_W    = 3;
    localparam int ROW_W    = 3;
    localparam int N_PIX    = 48;
    localparam int PIX_W    = 6;

    // Frames summed per run
    localparam int N_FRAMES = 4;
    localparam int FRAME_W  = 2;

    // Delay at the array centre, in samples
    localparam int DELAY_BASE = 8;

    // Microphone positions: 0 (-1,-1), 1 (+1,-1), 2 (-1,+1), 3 (+1,+1)
    localparam int MIC_X [N_MIC] = '{-1, 1, -1, 1};
    localparam int MIC_Y [N_MIC] = '{-1, -1, 1, 1};

    localparam int DRAIN_CYCLES = 2;          // Buffer read plus square stage

    typedef enum logic [2:0] {
        S_IDLE,
        S_RECORD,
        S_CALC,
        S_DRAIN,
        S_NEXT,
        S_DONE
    } scan_state_e;

endpackage

/* source/mic_ring_buffer.sv */
`timescale 1ns/100ps

module mic_ring_buffer (
    input  logic                          i_50M_clk,
    input  logic                          i_rst,
    input  logic                          i_clear,
    input  logic                          i_we,
    input  logic [beam_pkg::SAMPLE_W-1:0] i_data,
    input  logic [beam_pkg::PTR_W-1:0]    i_delay,
    input  logic                          i_rd_en,
    output logic [beam_pkg::SAMPLE_W-1:0] o_sample,
    output logic                          o_filled
);
    import beam_pkg::*;

    logic [SAMPLE_W-1:0] mem [BUF_DEPTH];
    logic [PTR_W-1:0]    wr_ptr_r;                  // Next slot to write
    logic [PTR_W:0]      count_r;                   // Saturates at BUF_DEPTH
    logic [PTR_W-1:0]    rd_addr;

    // Newest entry sits at wr_ptr - 1, delay 0 reads it
    assign rd_addr  = wr_ptr_r - PTR_W'(1) - i_delay;
    assign o_filled = (count_r == (PTR_W + 1)'(BUF_DEPTH));

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (i_we) begin
                wr_ptr_r <= wr_ptr_r + PTR_W'(1);   // Wraps at depth
            end
            if (i_clear) begin
                count_r <= '0;                      // Pointer keeps running
            end else if (i_we && !o_filled) begin
                count_r <= count_r + 1'b1;
            end
        end
    end

    always_ff @(posedge i_50M_clk) begin
        if (i_we) begin
            mem[wr_ptr_r] <= i_data;
        end
    end

    // Registered delayed read, one cycle after the pixel is issued
    always_ff @(posedge i_50M_clk) begin
        if (i_rd_en) begin
            o_sample <= mem[rd_addr];
        end
    end

endmodule

/* source/delay_generator.sv */
`timescale 1ns/100ps

module delay_generator (
    input  logic [beam_pkg::ROW_W-1:0]                   i_row,
    input  logic [beam_pkg::COL_W-1:0]                   i_col,
    output logic [beam_pkg::N_MIC-1:0][beam_pkg::PTR_W-1:0] o_delay
);
    import beam_pkg::*;

    // Offsets from the map centre, column 4 and row 3
    int sx;
    int sy;

    assign sx = int'(i_col) - MAP_COLS / 2;     // -4 to +3
    assign sy = int'(i_row) - MAP_ROWS / 2;     // -3 to +2

    // Steering delay per microphone
    // A microphone on the far side of the steered direction waits longer,
    // so its sample is taken further back in the ring buffer
    always_comb begin
        int d;
        d = 0;
        for (int k = 0; k < N_MIC; k++) begin
            d          = DELAY_BASE + MIC_X[k] * sx + MIC_Y[k] * sy;
            o_delay[k] = PTR_W'(d);             // Always 1 to 15
        end
    end

endmodule

/* source/sum_square_acc.sv */
`timescale 1ns/100ps

module sum_square_acc (
    input  logic                                            i_50M_clk,
    input  logic                                            i_rst,
    input  logic [beam_pkg::N_MIC-1:0][beam_pkg::SAMPLE_W-1:0] i_samples,
    input  logic [beam_pkg::ACC_W-1:0]                      i_old_value,
    input  logic                                            i_first_frame,
    output logic [beam_pkg::ACC_W-1:0]                      o_value
);
    import beam_pkg::*;

    logic signed [SUM_W-1:0]   sum;
    logic signed [2*SUM_W-1:0] square;
    logic [ACC_W-1:0]          square_ext;
    logic [ACC_W-1:0]          base;

    // Delay-and-sum over the four delayed samples
    always_comb begin
        sum = '0;
        for (int k = 0; k < N_MIC; k++) begin
            sum = sum + SUM_W'($signed(i_samples[k]));   // Sign extended
        end
        square = sum * sum;                              // Max 2**26
    end

    assign square_ext = {{(ACC_W - 2 * SUM_W){1'b0}}, square};

    // Frame 0 overwrites whatever the map held before
    assign base = i_first_frame ? '0 : i_old_value;

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            o_value <= '0;
        end else begin
            o_value <= base + square_ext;
        end
    end

endmodule

/* source/power_map_ram.sv */
`timescale 1ns/100ps

module power_map_ram (
    input  logic                       i_50M_clk,
    input  logic                       i_we,
    input  logic [beam_pkg::PIX_W-1:0] i_wr_addr,
    input  logic [beam_pkg::ACC_W-1:0] i_wr_data,
    input  logic [beam_pkg::PIX_W-1:0] i_scan_addr,
    input  logic [beam_pkg::PIX_W-1:0] i_rd_addr,
    output logic [beam_pkg::ACC_W-1:0] o_scan_data,
    output logic [beam_pkg::ACC_W-1:0] o_rd_data
);
    import beam_pkg::*;

    logic [ACC_W-1:0] mem [N_PIX];

    // Accumulated result, written two cycles after the scan read
    always_ff @(posedge i_50M_clk) begin
        if (i_we) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Old value for the accumulation
    always_ff @(posedge i_50M_clk) begin
        o_scan_data <= mem[i_scan_addr];
    end

    // Readout port, one cycle latency
    always_ff @(posedge i_50M_clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

/* source/scan_controller.sv */
`timescale 1ns/100ps

module scan_controller (
    input  logic                       i_50M_clk,
    input  logic                       i_rst,
    input  logic                       i_start,
    input  logic                       i_sample,
    input  logic                       i_buf_filled,
    output logic [beam_pkg::ROW_W-1:0] o_row,
    output logic [beam_pkg::COL_W-1:0] o_col,
    output logic                       o_rd_en,
    output logic                       o_first_frame,
    output logic                       o_wr_en,
    output logic [beam_pkg::PIX_W-1:0] o_wr_addr,
    output logic                       o_buf_we,
    output logic                       o_buf_clear,
    output logic                       o_done
);
    import beam_pkg::*;

    scan_state_e state_r, state_w;
    logic [ROW_W-1:0]   row_r, row_w;
    logic [COL_W-1:0]   col_r, col_w;
    logic [FRAME_W-1:0] frame_r, frame_w;
    logic [$clog2(DRAIN_CYCLES)-1:0] drain_r, drain_w;
    logic               last_col;
    logic               last_pix;
    logic [PIX_W-1:0]   pix_addr;
    logic               valid_d1_r, valid_d2_r;
    logic               first_d1_r;
    logic [PIX_W-1:0]   addr_d1_r, addr_d2_r;

    assign last_col = (col_r == COL_W'(MAP_COLS - 1));
    assign last_pix = last_col && (row_r == ROW_W'(MAP_ROWS - 1));
    assign pix_addr = PIX_W'(row_r * MAP_COLS + col_r);     // Row-major

    assign o_buf_clear = i_start && (state_r == S_IDLE || state_r == S_DONE);
    // Record until buffer 0 holds 16 samples; S_NEXT leaves on the first strobe
    assign o_buf_we    = (state_r == S_RECORD && !i_buf_filled) || (state_r == S_NEXT);
    assign o_rd_en     = (state_r == S_CALC);
    assign o_done      = (state_r == S_DONE);

    assign o_row         = row_r;
    assign o_col         = col_r;
    assign o_first_frame = first_d1_r;          // Lines up with the buffer output
    assign o_wr_en       = valid_d2_r;
    assign o_wr_addr     = addr_d2_r;

    always_comb begin
        state_w = state_r;
        row_w   = row_r;
        col_w   = col_r;
        frame_w = frame_r;
        drain_w = drain_r;
        case (state_r)
            S_IDLE, S_DONE: begin
                if (i_start) begin
                    frame_w = '0;
                    state_w = S_RECORD;
                end
            end
            S_RECORD: begin
                if (i_buf_filled) state_w = S_CALC;
            end
            S_CALC: begin
                if (last_pix) begin
                    row_w   = '0;
                    col_w   = '0;
                    drain_w = '0;
                    state_w = S_DRAIN;
                end else if (last_col) begin
                    col_w = '0;
                    row_w = row_r + 1'b1;
                end else begin
                    col_w = col_r + 1'b1;
                end
            end
            S_DRAIN: begin
                if (drain_r == $bits(drain_r)'(DRAIN_CYCLES - 1)) begin
                    if (frame_r == FRAME_W'(N_FRAMES - 1)) begin
                        state_w = S_DONE;
                    end else begin
                        frame_w = frame_r + 1'b1;
                        state_w = S_NEXT;
                    end
                end else begin
                    drain_w = drain_r + 1'b1;
                end
            end
            S_NEXT: begin
                if (i_sample) state_w = S_CALC;      // One new sample per frame
            end
            default: state_w = S_IDLE;
        endcase
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r    <= S_IDLE;
            row_r      <= '0;
            col_r      <= '0;
            frame_r    <= '0;
            drain_r    <= '0;
            valid_d1_r <= 1'b0;
            valid_d2_r <= 1'b0;
            first_d1_r <= 1'b0;
        end else begin
            state_r    <= state_w;
            row_r      <= row_w;
            col_r      <= col_w;
            frame_r    <= frame_w;
            drain_r    <= drain_w;
            valid_d1_r <= o_rd_en;
            valid_d2_r <= valid_d1_r;
            first_d1_r <= (frame_r == '0);
        end
    end

    // Write address follows the pixel through the two pipeline stages
    always_ff @(posedge i_50M_clk) begin
        addr_d1_r <= pix_addr;
        addr_d2_r <= addr_d1_r;
    end

endmodule

/* source/acoustic_imager_top.sv */
`timescale 1ns/100ps

module acoustic_imager_top (
    input  logic                                            i_50M_clk,
    input  logic                                            i_rst,
    input  logic                                            i_start,
    input  logic                                            i_sample,
    input  logic [beam_pkg::N_MIC-1:0][beam_pkg::SAMPLE_W-1:0] i_mic_data,
    input  logic [beam_pkg::PIX_W-1:0]                      i_rd_addr,
    output logic                                            o_accepting,
    output logic                                            o_done,
    output logic [beam_pkg::ACC_W-1:0]                      o_rd_data
);
    import beam_pkg::*;

    logic [ROW_W-1:0]                   row;
    logic [COL_W-1:0]                   col;
    logic [PIX_W-1:0]                   scan_addr;
    logic                               scan_rd_en;
    logic                               first_frame;
    logic                               wr_en;
    logic [PIX_W-1:0]                   wr_addr;
    logic                               buf_we;
    logic                               buf_store;
    logic                               buf_clear;
    logic [N_MIC-1:0]                   filled;
    logic [N_MIC-1:0][PTR_W-1:0]        delay;
    logic [N_MIC-1:0][SAMPLE_W-1:0]     samples;
    logic [ACC_W-1:0]                   old_value;
    logic [ACC_W-1:0]                   new_value;

    assign o_accepting = buf_we;
    assign buf_store   = buf_we & i_sample;
    assign scan_addr   = {row, col};            // MAP_COLS is 8, so row * 8 + col

    scan_controller u_scan_controller (
        .i_50M_clk     (i_50M_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .i_sample      (i_sample),
        .i_buf_filled  (filled[0]),
        .o_row         (row),
        .o_col         (col),
        .o_rd_en       (scan_rd_en),
        .o_first_frame (first_frame),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_buf_we      (buf_we),
        .o_buf_clear   (buf_clear),
        .o_done        (o_done)
    );

    delay_generator u_delay_generator (
        .i_row   (row),
        .i_col   (col),
        .o_delay (delay)
    );

    for (genvar k = 0; k < N_MIC; k++) begin : g_mic
        mic_ring_buffer u_mic_ring_buffer (
            .i_50M_clk (i_50M_clk),
            .i_rst     (i_rst),
            .i_clear   (buf_clear),
            .i_we      (buf_store),
            .i_data    (i_mic_data[k]),
            .i_delay   (delay[k]),
            .i_rd_en   (scan_rd_en),
            .o_sample  (samples[k]),
            .o_filled  (filled[k])
        );
    end

    sum_square_acc u_sum_square_acc (
        .i_50M_clk     (i_50M_clk),
        .i_rst         (i_rst),
        .i_samples     (samples),
        .i_old_value   (old_value),
        .i_first_frame (first_frame),
        .o_value       (new_value)
    );

    power_map_ram u_power_map_ram (
        .i_50M_clk   (i_50M_clk),
        .i_we        (wr_en),
        .i_wr_addr   (wr_addr),
        .i_wr_data   (new_value),
        .i_scan_addr (scan_addr),
        .i_rd_addr   (i_rd_addr),
        .o_scan_data (old_value),
        .o_rd_data   (o_rd_data)
    );

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
    output logic o_clk,
    output logic o_rst
);
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;             // 20 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clk);
        #2 o_rst = 1'b0;                        // Released with the other inputs
    end
endmodule

/* verif/tb_acoustic_imager.sv */
`timescale 1ns/100ps

module tb_acoustic_imager;
    import beam_pkg::*;

    localparam int RUN_TIMEOUT = 4000;          // Cycles allowed per capture run

    logic                           clk;
    logic                           rst;
    logic                           start;
    logic                           sample;
    logic [N_MIC-1:0][SAMPLE_W-1:0] mic_data;
    logic [PIX_W-1:0]               rd_addr;
    logic                           accepting;
    logic                           done;
    logic [ACC_W-1:0]               rd_data;

    logic [31:0] rng_state;
    int          error_count;
    int          timeout_count;
    int          run_index;
    int          history [$];                   // Mic k of accepted set i at i*N_MIC+k
    int          window_counts [$];             // Strobes taken per o_accepting window
    int          expected_map [N_PIX];

    clk_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    acoustic_imager_top i_dut (
        .i_50M_clk   (clk),
        .i_rst       (rst),
        .i_start     (start),
        .i_sample    (sample),
        .i_mic_data  (mic_data),
        .i_rd_addr   (rd_addr),
        .o_accepting (accepting),
        .o_done      (done),
        .o_rd_data   (rd_data)
    );

    function automatic logic [31:0] xorshift_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, msg, actual, expected);
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_drive_point();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < 10) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("ERROR: reset was never released");
            timeout_count++;
        end
        next_drive_point();
    endtask

    // Strobes before i_start must not open the sample gate
    task automatic check_idle_after_reset();
        for (int i = 0; i < 6; i++) begin
            sample = (i % 2 == 0);
            for (int k = 0; k < N_MIC; k++) begin
                mic_data[k] = SAMPLE_W'(xorshift_next());
            end
            @(negedge clk);
            check_equal(accepting, 1'b0, "o_accepting before i_start");
            check_equal(done, 1'b0, "o_done before i_start");
            next_drive_point();
        end
        sample = 1'b0;
    endtask

    // Mode 0 random samples, 1 all most negative, 2 all most positive
    task automatic run_capture(input int mode);
        int   cycles;
        logic prev_acc;
        history.delete();
        window_counts.delete();
        run_index++;
        start = 1'b1;
        next_drive_point();
        start    = 1'b0;
        cycles   = 0;
        prev_acc = 1'b0;
        while (done !== 1'b1 && cycles < RUN_TIMEOUT) begin
            sample = (xorshift_next() % 3 == 0);          // Random gaps
            for (int k = 0; k < N_MIC; k++) begin
                case (mode)
                    1:       mic_data[k] = 12'h800;
                    2:       mic_data[k] = 12'h7FF;
                    default: mic_data[k] = SAMPLE_W'(xorshift_next());
                endcase
            end
            @(negedge clk);
            if (accepting === 1'b1) begin
                if (!prev_acc) window_counts.push_back(0);
                if (sample) begin
                    for (int k = 0; k < N_MIC; k++) begin
                        history.push_back(int'($signed(mic_data[k])));
                    end
                    window_counts[window_counts.size() - 1] =
                        window_counts[window_counts.size() - 1] + 1;
                end
            end
            prev_acc = (accepting === 1'b1);
            next_drive_point();
            cycles++;
        end
        sample = 1'b0;
        if (done !== 1'b1) begin
            $display("ERROR: run %0d timed out waiting for o_done", run_index);
            timeout_count++;
        end
    endtask

    // One window of 16 strobes, then one per later frame
    task automatic check_windows();
        check_equal(window_counts.size(), N_FRAMES,
                    $sformatf("run %0d number of accept windows", run_index));
        foreach (window_counts[i]) begin
            check_equal(window_counts[i], (i == 0) ? BUF_DEPTH : 1,
                        $sformatf("run %0d strobes in window %0d", run_index, i));
        end
    endtask

    task automatic compute_expected();
        int n_sets;
        int newest;
        int sx;
        int sy;
        int d;
        int s;
        int acc;
        n_sets = history.size() / N_MIC;
        if (n_sets < BUF_DEPTH + N_FRAMES - 1) begin
            $display("ERROR: run %0d stored too few samples to build the model map", run_index);
            error_count++;
            return;
        end
        for (int p = 0; p < N_PIX; p++) begin
            sx  = p % MAP_COLS - 4;
            sy  = p / MAP_COLS - 3;
            acc = 0;
            for (int f = 0; f < N_FRAMES; f++) begin
                newest = BUF_DEPTH - 1 + f;           // One new set per later frame
                s      = 0;
                for (int k = 0; k < N_MIC; k++) begin
                    d = DELAY_BASE + MIC_X[k] * sx + MIC_Y[k] * sy;
                    s = s + history[(newest - d) * N_MIC + k];
                end
                acc = acc + s * s;
            end
            expected_map[p] = acc;
        end
    endtask

    // Shuffled addresses, one per cycle, data checked one cycle later
    task automatic read_map_random();
        int perm [N_PIX];
        int j;
        int tmp;
        for (int i = 0; i < N_PIX; i++) perm[i] = i;
        for (int i = N_PIX - 1; i > 0; i--) begin
            j       = int'(xorshift_next() % 32'(i + 1));
            tmp     = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        for (int i = 0; i <= N_PIX; i++) begin
            if (i < N_PIX) rd_addr = PIX_W'(perm[i]);
            @(negedge clk);
            if (i > 0) begin
                check_equal(rd_data, expected_map[perm[i - 1]],
                            $sformatf("run %0d map word %0d", run_index, perm[i - 1]));
            end
            check_equal(done, 1'b1, "o_done held during readout");
            next_drive_point();
        end
    endtask

    task automatic run_and_check(input int mode);
        run_capture(mode);
        if (timeout_count == 0) begin
            check_windows();
            compute_expected();
            read_map_random();
        end
    endtask

    initial begin
        start         = 1'b0;
        sample        = 1'b0;
        mic_data      = '0;
        rd_addr       = '0;
        rng_state     = 32'd83;
        error_count   = 0;
        timeout_count = 0;
        run_index     = 0;
        wait_reset_release();
        check_idle_after_reset();
        run_and_check(0);                       // First random run
        run_and_check(0);                       // Restart from S_DONE, fresh map
        run_and_check(1);                       // All microphones at -2048
        run_and_check(2);                       // All microphones at +2047
        $display("Closing report: %0d check failures, %0d timeouts",
                 error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
source/beam_pkg.sv
source/mic_ring_buffer.sv
source/delay_generator.sv
source/sum_square_acc.sv
source/power_map_ram.sv
source/scan_controller.sv
source/acoustic_imager_top.sv
verif/clk_gen.sv
verif/tb_acoustic_imager.sv

/* Bender.yml */
package:
  name: acoustic_imager

sources:
  - files:
      - source/beam_pkg.sv
      - source/mic_ring_buffer.sv
      - source/delay_generator.sv
      - source/sum_square_acc.sv
      - source/power_map_ram.sv
      - source/scan_controller.sv
      - source/acoustic_imager_top.sv
  - target: test
    files:
      - verif/clk_gen.sv
      - verif/tb_acoustic_imager.sv
